// ==== include/riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// data path and address width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

// instruction memory word address width, 256 words
`define IMEM_AW 8

// data memory byte address width, 1 KiB
`define DMEM_AW 10

`endif

// ==== hw/riscvPkg.sv ====
`default_nettype none

package riscvPkg;

    // base opcodes in use
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluCtrlE;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immSrcE;

    // write-back source
    typedef enum logic [2:0] {
        resAlu,
        resMem,
        resPcPlus4,
        resPcTarget,
        resImm
    } resultSrcE;

    // funct3 width codes for loads and stores
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

endpackage

`default_nettype wire

// ==== hw/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

    riscvPkg::aluCtrlE   aluControl;
    logic                aluSrc;
    riscvPkg::immSrcE    immSrc;
    riscvPkg::resultSrcE resultSrc;
    logic                regWrite;
    logic                memWrite;
    logic                pcSrc;
    // jalr uses rs1 as the target base
    logic                jumpReg;

    modport controller (
        output aluControl, aluSrc, immSrc, resultSrc,
        output regWrite, memWrite, pcSrc, jumpReg
    );

    modport datapath (
        input aluControl, aluSrc, immSrc, resultSrc,
        input regWrite, memWrite, pcSrc, jumpReg
    );

endinterface

`default_nettype wire

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module controlUnit (
    input  logic [`XLEN-1:0] instr,
    input  logic             zero,
    input  logic             negative,
    input  logic             carry,
    input  logic             overflow,
    ctrlIf.controller        ctrl
);

    // coarse ALU request from the main decoder
    typedef enum logic [1:0] {
        aluOpAdd,
        aluOpSub,
        aluOpFunct
    } aluOpE;

    riscvPkg::opcodeE opcode;
    logic [2:0]       funct3;
    logic             funct7b5;
    aluOpE            aluOp;
    logic             branch;
    logic             jump;
    logic             signedLess;
    logic             takeBranch;

    assign opcode   = riscvPkg::opcodeE'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // main decoder
    always_comb begin
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSrc    = riscvPkg::immI;
        ctrl.resultSrc = riscvPkg::resAlu;
        ctrl.jumpReg   = 1'b0;
        aluOp          = aluOpAdd;
        branch         = 1'b0;
        jump           = 1'b0;
        case (opcode)
            riscvPkg::opOp: begin
                ctrl.regWrite = 1'b1;
                aluOp         = aluOpFunct;
            end
            riscvPkg::opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                aluOp         = aluOpFunct;
            end
            riscvPkg::opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = riscvPkg::resMem;
            end
            riscvPkg::opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = riscvPkg::immS;
            end
            riscvPkg::opBranch: begin
                ctrl.immSrc = riscvPkg::immB;
                aluOp       = aluOpSub;
                branch      = 1'b1;
            end
            riscvPkg::opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = riscvPkg::immJ;
                ctrl.resultSrc = riscvPkg::resPcPlus4;
                jump           = 1'b1;
            end
            riscvPkg::opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = riscvPkg::resPcPlus4;
                ctrl.jumpReg   = 1'b1;
                jump           = 1'b1;
            end
            riscvPkg::opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = riscvPkg::immU;
                ctrl.resultSrc = riscvPkg::resImm;
            end
            riscvPkg::opAuipc: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = riscvPkg::immU;
                ctrl.resultSrc = riscvPkg::resPcTarget;
            end
            default: ;
        endcase
    end

    // ALU decoder, sub only for register ops with funct7 bit 5
    always_comb begin
        case (aluOp)
            aluOpAdd: ctrl.aluControl = riscvPkg::aluAdd;
            aluOpSub: ctrl.aluControl = riscvPkg::aluSub;
            default: begin
                case (funct3)
                    3'b000: ctrl.aluControl = (opcode == riscvPkg::opOp && funct7b5) ?
                                              riscvPkg::aluSub : riscvPkg::aluAdd;
                    3'b001: ctrl.aluControl = riscvPkg::aluSll;
                    3'b010: ctrl.aluControl = riscvPkg::aluSlt;
                    3'b011: ctrl.aluControl = riscvPkg::aluSltu;
                    3'b100: ctrl.aluControl = riscvPkg::aluXor;
                    3'b101: ctrl.aluControl = funct7b5 ? riscvPkg::aluSra : riscvPkg::aluSrl;
                    3'b110: ctrl.aluControl = riscvPkg::aluOr;
                    default: ctrl.aluControl = riscvPkg::aluAnd;
                endcase
            end
        endcase
    end

    // branch condition from the flags of rs1 - rs2
    assign signedLess = negative ^ overflow;

    always_comb begin
        case (funct3)
            3'b000:  takeBranch = zero;
            3'b001:  takeBranch = ~zero;
            3'b100:  takeBranch = signedLess;
            3'b101:  takeBranch = ~signedLess;
            // no borrow means rs1 >= rs2 unsigned
            3'b110:  takeBranch = ~carry;
            3'b111:  takeBranch = carry;
            default: takeBranch = 1'b0;
        endcase
    end

    assign ctrl.pcSrc = jump | (branch & takeBranch);

endmodule

`default_nettype wire

// ==== hw/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module fetchUnit (
    input  logic                CLK,
    input  logic                rstN,
    input  logic [`XLEN-1:0]    pcNext,
    input  logic                progWe,
    input  logic [`IMEM_AW-1:0] progAddr,
    input  logic [`XLEN-1:0]    progData,
    output logic [`XLEN-1:0]    pc,
    output logic [`XLEN-1:0]    instr
);

    localparam int ImemWords = 1 << `IMEM_AW;

    logic [`XLEN-1:0]    imem [0:ImemWords-1];
    logic [`IMEM_AW-1:0] wordAddr;

    // program counter, held at zero in reset
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // word address is pc / 4
    assign wordAddr = pc[`IMEM_AW+1:2];
    assign instr    = imem[wordAddr];

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module regFile (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   we,
    input  logic [`XLEN-1:0]       wd,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2,
    output logic [`XLEN-1:0]       a0
);

    localparam int NumRegs = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [0:NumRegs-1];

    // x0 is never written, so it stays zero after reset
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];
    assign a0  = regs[10];

endmodule

`default_nettype wire

// ==== hw/immExtend.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module immExtend (
    input  logic [`XLEN-1:0] instr,
    input  riscvPkg::immSrcE immSrc,
    output logic [`XLEN-1:0] immExt
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSrc)
            riscvPkg::immI: immExt = {{(`XLEN-12){sign}}, instr[31:20]};
            riscvPkg::immS: immExt = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            // branch offsets are in half words
            riscvPkg::immB: immExt = {{(`XLEN-12){sign}}, instr[7], instr[30:25],
                                      instr[11:8], 1'b0};
            riscvPkg::immU: immExt = {instr[31:12], 12'b0};
            riscvPkg::immJ: immExt = {{(`XLEN-20){sign}}, instr[19:12], instr[20],
                                      instr[30:21], 1'b0};
            default:        immExt = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module alu (
    input  logic [`XLEN-1:0]  srcA,
    input  logic [`XLEN-1:0]  srcB,
    input  riscvPkg::aluCtrlE aluControl,
    output logic [`XLEN-1:0]  result,
    output logic              zero,
    output logic              negative,
    output logic              carry,
    output logic              overflow
);

    localparam int ShW = $clog2(`XLEN);

    logic             isSub;
    logic [`XLEN-1:0] opB;
    logic [`XLEN:0]   sum;
    logic [ShW-1:0]   shamt;

    // sub and both compares use srcA + ~srcB + 1
    assign isSub = aluControl inside {riscvPkg::aluSub, riscvPkg::aluSlt, riscvPkg::aluSltu};
    assign opB   = isSub ? ~srcB : srcB;
    assign sum   = {1'b0, srcA} + {1'b0, opB} + {{`XLEN{1'b0}}, isSub};
    assign shamt = srcB[ShW-1:0];

    assign carry    = sum[`XLEN];
    // operands of equal sign giving a result of the other sign
    assign overflow = (srcA[`XLEN-1] == opB[`XLEN-1]) && (sum[`XLEN-1] != srcA[`XLEN-1]);

    always_comb begin
        case (aluControl)
            riscvPkg::aluAdd,
            riscvPkg::aluSub:  result = sum[`XLEN-1:0];
            riscvPkg::aluAnd:  result = srcA & srcB;
            riscvPkg::aluOr:   result = srcA | srcB;
            riscvPkg::aluXor:  result = srcA ^ srcB;
            riscvPkg::aluSlt:  result = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ overflow};
            riscvPkg::aluSltu: result = {{(`XLEN-1){1'b0}}, ~carry};
            riscvPkg::aluSll:  result = srcA << shamt;
            riscvPkg::aluSrl:  result = srcA >> shamt;
            riscvPkg::aluSra:  result = $signed(srcA) >>> shamt;
            default:           result = '0;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[`XLEN-1];

endmodule

`default_nettype wire

// ==== hw/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module dataMem (
    input  logic                CLK,
    input  logic [`DMEM_AW-1:0] addr,
    input  logic [2:0]          funct3,
    input  logic                we,
    input  logic [`XLEN-1:0]    wd,
    output logic [`XLEN-1:0]    rd
);

    localparam int Words = 1 << (`DMEM_AW - 2);

    logic [3:0][7:0]      mem [0:Words-1];
    logic [`DMEM_AW-3:0]  wordIdx;
    logic [1:0]           lane;
    logic [3:0]           laneEn;
    logic [`XLEN-1:0]     wdLanes;
    logic [`XLEN-1:0]     shifted;

    assign wordIdx = addr[`DMEM_AW-1:2];
    assign lane    = addr[1:0];

    // store width picks the lanes and replicates the data onto them
    always_comb begin
        case (funct3)
            riscvPkg::f3Byte: begin
                laneEn  = 4'b0001 << lane;
                wdLanes = {4{wd[7:0]}};
            end
            riscvPkg::f3Half: begin
                laneEn  = 4'b0011 << {lane[1], 1'b0};
                wdLanes = {2{wd[15:0]}};
            end
            default: begin
                laneEn  = 4'b1111;
                wdLanes = wd;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (laneEn[i]) begin
                    mem[wordIdx][i] <= wdLanes[8*i +: 8];
                end
            end
        end
    end

    // bring the addressed byte or half down to bit zero
    assign shifted = mem[wordIdx] >> {lane, 3'b000};

    always_comb begin
        case (funct3)
            riscvPkg::f3Byte:  rd = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            riscvPkg::f3Half:  rd = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            riscvPkg::f3ByteU: rd = {{(`XLEN-8){1'b0}}, shifted[7:0]};
            riscvPkg::f3HalfU: rd = {{(`XLEN-16){1'b0}}, shifted[15:0]};
            default:           rd = mem[wordIdx];
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/riscV.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module riscV (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   progWe,
    input  logic [`IMEM_AW-1:0]    progAddr,
    input  logic [`XLEN-1:0]       progData,
    output logic [`XLEN-1:0]       pc,
    output logic [`XLEN-1:0]       a0,
    output logic                   wbEn,
    output logic [`REG_ADDR_W-1:0] wbAddr,
    output logic [`XLEN-1:0]       wbData
);

    logic [`XLEN-1:0]       instr;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [`XLEN-1:0]       rd1;
    logic [`XLEN-1:0]       rd2;
    logic [`XLEN-1:0]       immExt;
    logic [`XLEN-1:0]       srcB;
    logic [`XLEN-1:0]       aluResult;
    logic                   zero;
    logic                   negative;
    logic                   carry;
    logic                   overflow;
    logic [`XLEN-1:0]       readData;
    logic [`XLEN-1:0]       pcPlus4;
    logic [`XLEN-1:0]       targetSum;
    logic [`XLEN-1:0]       pcTarget;
    logic [`XLEN-1:0]       pcNext;
    logic [`XLEN-1:0]       result;

    ctrlIf ctrl0 ();

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    fetchUnit fetch0 (
        .CLK      (CLK),
        .rstN     (rstN),
        .pcNext   (pcNext),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr)
    );

    controlUnit ctrlUnit0 (
        .instr    (instr),
        .zero     (zero),
        .negative (negative),
        .carry    (carry),
        .overflow (overflow),
        .ctrl     (ctrl0)
    );

    regFile regs0 (
        .CLK  (CLK),
        .rstN (rstN),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .we   (ctrl0.regWrite),
        .wd   (result),
        .rd1  (rd1),
        .rd2  (rd2),
        .a0   (a0)
    );

    immExtend imm0 (
        .instr  (instr),
        .immSrc (ctrl0.immSrc),
        .immExt (immExt)
    );

    alu alu0 (
        .srcA       (rd1),
        .srcB       (srcB),
        .aluControl (ctrl0.aluControl),
        .result     (aluResult),
        .zero       (zero),
        .negative   (negative),
        .carry      (carry),
        .overflow   (overflow)
    );

    // stores are blocked while reset holds the core
    dataMem dmem0 (
        .CLK    (CLK),
        .addr   (aluResult[`DMEM_AW-1:0]),
        .funct3 (funct3),
        .we     (ctrl0.memWrite & rstN),
        .wd     (rd2),
        .rd     (readData)
    );

    assign srcB = ctrl0.aluSrc ? immExt : rd2;

    // pc or rs1 base, jalr target has bit zero cleared
    assign pcPlus4   = pc + `XLEN'd4;
    assign targetSum = (ctrl0.jumpReg ? rd1 : pc) + immExt;
    assign pcTarget  = {targetSum[`XLEN-1:1], targetSum[0] & ~ctrl0.jumpReg};
    assign pcNext    = ctrl0.pcSrc ? pcTarget : pcPlus4;

    always_comb begin
        case (ctrl0.resultSrc)
            riscvPkg::resMem:      result = readData;
            riscvPkg::resPcPlus4:  result = pcPlus4;
            riscvPkg::resPcTarget: result = pcTarget;
            riscvPkg::resImm:      result = immExt;
            default:               result = aluResult;
        endcase
    end

    // write-back mirror for the current instruction
    assign wbEn   = ctrl0.regWrite;
    assign wbAddr = rd;
    assign wbData = result;

endmodule

`default_nettype wire

// ==== tb/tbRiscV.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module tbRiscV;

    localparam int ProgLen       = 40;
    localparam int NumTests      = 10;
    localparam int ResetCycles   = 8;
    localparam int LoadCycles    = (ProgLen > ResetCycles) ? ProgLen : ResetCycles;
    localparam int TimeoutCycles = NumTests * (LoadCycles + ProgLen + ResetCycles + 20);
    localparam logic [`XLEN-1:0] LoopAddr = (ProgLen - 1) * 4;

    logic                   CLK = 1'b0;
    logic                   rstN;
    logic                   progWe;
    logic [`IMEM_AW-1:0]    progAddr;
    logic [`XLEN-1:0]       progData;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       a0;
    logic                   wbEn;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;

    logic [31:0] lfsr = 32'd97;
    int          cycleCount = 0;
    string       testName;
    logic [31:0] prog [0:ProgLen-1];
    // start slot of the jalr sequence that holds a slot or -1 if none
    int          grp [0:ProgLen-1];
    int          kind [0:ProgLen-1];

    // instruction-set model state
    logic [31:0] mPc;
    logic [31:0] xm [0:31];
    logic [7:0]  mm [0:(1 << `DMEM_AW)-1];

    riscV dut0 (
        .CLK      (CLK),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .a0       (a0),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            failRun();
        end
    end

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Mismatch in %s (%s): expected %h, actual %h", testName, what, expected, actual);
        failRun();
    endtask

    // galois LFSR with taps 32 31 29 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // x10 is picked often so a0 sees plenty of traffic
    function automatic logic [4:0] pickRd();
        return (randBits(2) == 0) ? 5'd10 : 5'(randBits(4));
    endfunction

    function automatic int pickTarget(input int from);
        int t;
        t = from + 1 + int'(randBits(4)) % (ProgLen - 1 - from);
        if (grp[t] >= 0) begin
            t = grp[t];
        end
        return t;
    endfunction

    function automatic logic [31:0] alignedOffset(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return randBits(4);
            2'd1:    return randBits(3) << 1;
            default: return randBits(2) << 2;
        endcase
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    // RV32I integer ops where alt selects sub or sra
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic modelExec(input logic [31:0] ins, output logic wbE, output logic [31:0] wbD);
        logic [31:0]         r1;
        logic [31:0]         r2;
        logic [31:0]         immI;
        logic [31:0]         immS;
        logic [31:0]         immB;
        logic [31:0]         immU;
        logic [31:0]         immJ;
        logic [31:0]         nextPc;
        logic [31:0]         addr;
        logic [`DMEM_AW-1:0] ma;
        logic [2:0]          f3;
        logic                take;
        f3     = ins[14:12];
        r1     = xm[ins[19:15]];
        r2     = xm[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU   = {ins[31:12], 12'b0};
        immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = mPc + 4;
        wbE    = 1'b1;
        wbD    = '0;
        case (ins[6:0])
            7'h33: wbD = aluRef(f3, ins[30], r1, r2);
            7'h13: wbD = aluRef(f3, (f3 == 3'd5) && ins[30], r1, immI);
            7'h03: begin
                addr = r1 + immI;
                ma   = addr[`DMEM_AW-1:0];
                case (f3)
                    riscvPkg::f3Byte:  wbD = {{24{mm[ma][7]}}, mm[ma]};
                    riscvPkg::f3Half:  wbD = {{16{mm[ma+1][7]}}, mm[ma+1], mm[ma]};
                    riscvPkg::f3Word:  wbD = {mm[ma+3], mm[ma+2], mm[ma+1], mm[ma]};
                    riscvPkg::f3ByteU: wbD = {24'b0, mm[ma]};
                    default:           wbD = {16'b0, mm[ma+1], mm[ma]};
                endcase
            end
            7'h23: begin
                wbE  = 1'b0;
                addr = r1 + immS;
                ma   = addr[`DMEM_AW-1:0];
                mm[ma] = r2[7:0];
                if (f3 != riscvPkg::f3Byte) begin
                    mm[ma+1] = r2[15:8];
                end
                if (f3 == riscvPkg::f3Word) begin
                    mm[ma+2] = r2[23:16];
                    mm[ma+3] = r2[31:24];
                end
            end
            7'h63: begin
                wbE = 1'b0;
                case (f3)
                    3'd0:    take = (r1 == r2);
                    3'd1:    take = (r1 != r2);
                    3'd4:    take = ($signed(r1) < $signed(r2));
                    3'd5:    take = ($signed(r1) >= $signed(r2));
                    3'd6:    take = (r1 < r2);
                    default: take = (r1 >= r2);
                endcase
                if (take) begin
                    nextPc = mPc + immB;
                end
            end
            7'h6F: begin
                wbD    = mPc + 4;
                nextPc = mPc + immJ;
            end
            7'h67: begin
                wbD    = mPc + 4;
                nextPc = (r1 + immI) & ~32'd1;
            end
            7'h37: wbD = immU;
            7'h17: wbD = mPc + immU;
            default: begin
                $display("Model met an instruction it does not support: %h", ins);
                failRun();
            end
        endcase
        if (wbE && ins[11:7] != 5'd0) begin
            xm[ins[11:7]] = wbD;
        end
        mPc = nextPc;
    endtask

    task automatic genProgram();
        int          s;
        int          k;
        int          t;
        int          n;
        logic [4:0]  rd;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [4:0]  tmp;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] imm;
        logic [31:0] off;
        for (int i = 0; i < ProgLen; i++) begin
            grp[i]  = -1;
            kind[i] = 0;
        end
        // kinds come first so jumps never land inside a jalr sequence
        s = 5;
        while (s < ProgLen - 1) begin
            k = int'(randBits(4)) % 9;
            if (k == 8 && s + 2 < ProgLen - 2) begin
                grp[s]   = s;
                grp[s+1] = s;
                grp[s+2] = s;
                kind[s]  = 8;
                s = s + 3;
            end else begin
                kind[s] = (k == 8) ? 1 : k;
                s = s + 1;
            end
        end
        // the word at address zero writes a0 so reset has a write to hold off
        prog[0] = encU({1'b1, 19'(randBits(19))}, 5'd10, 7'h37);
        // clear the data window so loads never read unwritten bytes
        for (int i = 0; i < 4; i++) begin
            prog[i+1] = encS(32'(i * 4), 5'd0, 5'd0, riscvPkg::f3Word);
        end
        // final self-loop
        prog[ProgLen-1] = encJ(32'd0, 5'd0);
        s = 5;
        while (s < ProgLen - 1) begin
            rd  = pickRd();
            r1  = 5'(randBits(4));
            r2  = 5'(randBits(4));
            f3  = 3'(randBits(3));
            alt = (randBits(1) != 0);
            imm = randBits(12);
            case (kind[s])
                0: prog[s] = encR({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0},
                                  r2, r1, f3, rd, 7'h33);
                1: begin
                    if (f3 == 3'd1) begin
                        imm = {27'b0, imm[4:0]};
                    end else if (f3 == 3'd5) begin
                        imm = {21'b0, alt, 5'b0, imm[4:0]};
                    end
                    prog[s] = encI(imm, r1, f3, rd, 7'h13);
                end
                2: prog[s] = encU(20'(randBits(20)), rd, 7'h37);
                3: prog[s] = encU(20'(randBits(20)), rd, 7'h17);
                4: begin
                    n  = int'(randBits(3)) % 5;
                    f3 = (n < 3) ? 3'(n) : 3'(n + 1);
                    prog[s] = encI(alignedOffset(f3), 5'd0, f3, rd, 7'h03);
                end
                5: begin
                    f3 = 3'(int'(randBits(2)) % 3);
                    prog[s] = encS(alignedOffset(f3), r2, 5'd0, f3);
                end
                6: begin
                    n  = int'(randBits(3)) % 6;
                    f3 = (n < 2) ? 3'(n) : 3'(n + 2);
                    t  = pickTarget(s);
                    prog[s] = encB(32'((t - s) * 4), r2, r1, f3);
                end
                7: begin
                    t = pickTarget(s);
                    prog[s] = encJ(32'((t - s) * 4), rd);
                end
                default: begin
                    // lui and addi build the base and an odd sum checks that bit zero is cleared
                    tmp = 5'(1 + int'(randBits(4)) % 15);
                    off = randBits(3);
                    t   = pickTarget(s + 2);
                    prog[s]   = encU(20'd0, tmp, 7'h37);
                    prog[s+1] = encI(32'(t * 4) + randBits(1) - off, tmp, 3'd0, tmp, 7'h13);
                    prog[s+2] = encI(off, tmp, 3'd0, rd, 7'h67);
                end
            endcase
            s = s + ((kind[s] == 8) ? 3 : 1);
        end
    endtask

    task automatic checkStep();
        logic [31:0] ins;
        logic        expWbEn;
        logic [31:0] expWbData;
        logic [4:0]  expRd;
        assert (pc === mPc) else reportMismatch("pc", mPc, pc);
        assert (a0 === xm[10]) else reportMismatch("a0", xm[10], a0);
        ins   = prog[int'(mPc >> 2)];
        expRd = ins[11:7];
        modelExec(ins, expWbEn, expWbData);
        assert (wbEn === expWbEn) else reportMismatch("wbEn", {31'b0, expWbEn}, {31'b0, wbEn});
        if (expWbEn) begin
            assert (wbAddr === expRd)
                else reportMismatch("wbAddr", {27'b0, expRd}, {27'b0, wbAddr});
            assert (wbData === expWbData) else reportMismatch("wbData", expWbData, wbData);
        end
    endtask

    task automatic runTest(input int t);
        testName = $sformatf("randomProgram%0d", t);
        genProgram();
        @(posedge CLK);
        rstN   <= 1'b0;
        progWe <= 1'b0;
        // load the program while the core is held in reset
        for (int c = 0; c < LoadCycles; c++) begin
            @(posedge CLK);
            progWe   <= (c < ProgLen);
            progAddr <= `IMEM_AW'(c);
            progData <= (c < ProgLen) ? prog[c] : '0;
            @(negedge CLK);
            assert (pc === '0) else reportMismatch("pc during reset", 32'd0, pc);
            assert (a0 === '0) else reportMismatch("a0 during reset", 32'd0, a0);
        end
        @(posedge CLK);
        progWe <= 1'b0;
        rstN   <= 1'b1;
        mPc = '0;
        for (int i = 0; i < 32; i++) begin
            xm[i] = '0;
        end
        for (int i = 0; i < (1 << `DMEM_AW); i++) begin
            mm[i] = '0;
        end
        // one instruction per cycle until the core sits on the self-loop
        do begin
            @(negedge CLK);
            checkStep();
        end while (pc !== LoopAddr);
        repeat (2) begin
            @(negedge CLK);
            checkStep();
        end
    endtask

    initial begin
        rstN     <= 1'b0;
        progWe   <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hw/riscvPkg.sv
hw/ctrlIf.sv
hw/controlUnit.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/immExtend.sv
hw/alu.sv
hw/dataMem.sv
hw/riscV.sv
tb/tbRiscV.sv
